// File: rtl/core_ctrl_config.svh
`ifndef CORE_CTRL_CONFIG_SVH
`define CORE_CTRL_CONFIG_SVH

// controller state code width
`define CTRL_STATE_W 4
// fetch stage pc source select width
`define PC_SEL_W 3
// resolved id-stage event code width
`define ID_EVENT_W 3

`endif

// File: rtl/ctrl_pkg.sv
`include "core_ctrl_config.svh"

`default_nettype none

package ctrl_pkg;

  //////////////////////////////////////////////////
  // controller state
  //////////////////////////////////////////////////

  // debug states come in pairs, the _SLEEP ones return to SLEEP
  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN,
    DBG_SIGNAL,
    DBG_SIGNAL_SLEEP,
    DBG_WAIT,
    DBG_WAIT_SLEEP
  } ctrl_state_e;

  //////////////////////////////////////////////////
  // id-stage events
  //////////////////////////////////////////////////

  // one code per cycle, already priority resolved
  typedef enum logic [`ID_EVENT_W-1:0] {
    EV_NONE,
    // branch or jump target is ready
    EV_REDIRECT,
    EV_FLUSH_INT,
    EV_FLUSH_MRET,
    // wfi or ebreak
    EV_FLUSH_OTHER,
    EV_IRQ,
    EV_DBG
  } id_event_e;

  // why the pipe is being flushed, kept for the FLUSH cycle
  typedef enum logic [1:0] {
    FC_INT,
    FC_MRET,
    FC_OTHER
  } flush_cause_e;

endpackage

`default_nettype wire

// File: rtl/fetch_pkg.sv
`include "core_ctrl_config.svh"

`default_nettype none

package fetch_pkg;

  // pc source select towards the prefetcher
  // encodings match the fetch stage pc mux
  typedef enum logic [`PC_SEL_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101,
    // next pc written by the debug unit
    PC_DBG_NPC   = 3'b111
  } pc_sel_e;

endpackage

`default_nettype wire

// File: rtl/id_event_if.sv
`default_nettype none

interface id_event_if;
  import ctrl_pkg::*;

  // fsm sits in DECODE
  logic      decode_active;
  // resolved event, EV_NONE outside DECODE
  id_event_e ev;
  // DECODE with a valid instruction in ID
  logic      is_decoding;
  // flush or irq, stop IF and ID this cycle
  logic      halt_req;

  // arbiter side
  modport arb (
    input  decode_active,
    output ev,
    output is_decoding,
    output halt_req
  );

  // state machine side
  modport fsm (
    output decode_active,
    input  ev,
    input  halt_req
  );

endinterface

`default_nettype wire

// File: rtl/id_event_arbiter.sv
`default_nettype none

module id_event_arbiter (
  id_event_if.arb ev_o,

  input  logic instr_valid_i,
  input  logic branch_set_i,
  input  logic jump_set_i,
  input  logic int_req_i,
  input  logic mret_insn_i,
  input  logic pipe_flush_i,
  input  logic ebrk_insn_i,
  input  logic ext_req_i,
  input  logic instr_multicycle_i,
  input  logic branch_in_id_i,
  input  logic branch_taken_ex_i,
  input  logic dbg_req_i,
  input  logic illegal_insn_i,

  output logic deassert_we_o
);
  import ctrl_pkg::*;

  id_event_e ev_d;
  logic      decoding;

  //////////////////////////////////////////////////
  // event priority
  //////////////////////////////////////////////////

  // redirect first, then the flushes, then irq and debug
  always_comb begin
    ev_d = EV_NONE;
    if (ev_o.decode_active) begin
      if (instr_valid_i) begin
        if (branch_set_i || jump_set_i) begin
          ev_d = EV_REDIRECT;
        end else if (int_req_i) begin
          ev_d = EV_FLUSH_INT;
        end else if (mret_insn_i) begin
          ev_d = EV_FLUSH_MRET;
        end else if (pipe_flush_i || ebrk_insn_i) begin
          // wfi and ebreak share one flush path
          ev_d = EV_FLUSH_OTHER;
        end else if (ext_req_i && !instr_multicycle_i && !branch_in_id_i) begin
          // irq waits for multicycle ops and branches in ID to finish
          ev_d = EV_IRQ;
        end else if (dbg_req_i && !branch_taken_ex_i) begin
          ev_d = EV_DBG;
        end
      end else if (ext_req_i) begin
        // empty ID stage, only an irq can be taken
        ev_d = EV_IRQ;
      end
    end
  end

  assign decoding = ev_o.decode_active & instr_valid_i;

  assign ev_o.ev          = ev_d;
  assign ev_o.is_decoding = decoding;

  // debug only halts IF, so it is left out here
  assign ev_o.halt_req = (ev_d == EV_FLUSH_INT)   ||
                         (ev_d == EV_FLUSH_MRET)  ||
                         (ev_d == EV_FLUSH_OTHER) ||
                         (ev_d == EV_IRQ);

  //////////////////////////////////////////////////
  // write enable
  //////////////////////////////////////////////////

  // no regfile write outside decode or for an illegal insn
  assign deassert_we_o = ~decoding | illegal_insn_i;

endmodule

`default_nettype wire

// File: rtl/ctrl_fsm.sv
`default_nettype none

module ctrl_fsm (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              fetch_enable_i,
  input  logic              ext_req_i,
  input  logic              dbg_req_i,
  input  logic              dbg_stall_i,
  input  logic              dbg_jump_req_i,
  input  logic              id_ready_i,

  id_event_if.fsm           ev_i,

  output logic              ctrl_busy_o,
  output logic              instr_req_o,
  output logic              pc_set_o,
  output fetch_pkg::pc_sel_e pc_mux_o,
  output logic              halt_if_o,
  output logic              halt_id_o,
  output logic              exc_ack_o,
  output logic              irq_ack_o,
  output logic              exc_save_if_o,
  output logic              exc_save_id_o,
  output logic              exc_restore_id_o,
  output logic              dbg_ack_o
);
  import ctrl_pkg::*;
  import fetch_pkg::*;

  ctrl_state_e  state_q, state_d;
  flush_cause_e cause_q, cause_d;

  assign ev_i.decode_active = (state_q == DECODE);

  // map the flush event onto its cause
  always_comb begin
    case (ev_i.ev)
      EV_FLUSH_INT:  cause_d = FC_INT;
      EV_FLUSH_MRET: cause_d = FC_MRET;
      default:       cause_d = FC_OTHER;
    endcase
  end

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;
    exc_ack_o        = 1'b0;
    irq_ack_o        = 1'b0;
    exc_save_if_o    = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;
    dbg_ack_o        = 1'b0;

    case (state_q)
      // idle until fetch is enabled, debug may still break in
      RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end else if (dbg_req_i) begin
          state_d = DBG_SIGNAL;
        end
      end

      // load the boot address into the prefetcher
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (dbg_req_i) begin
          // wake-up pending means debug returns to decode, not sleep
          if (fetch_enable_i || ext_req_i) begin
            state_d = DBG_SIGNAL;
          end else begin
            state_d = DBG_SIGNAL_SLEEP;
          end
        end else if (fetch_enable_i || ext_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i && !dbg_stall_i) begin
          state_d = DECODE;
        end
        // pipe is empty here, so an irq can go straight in
        if (ext_req_i) begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN;
        end
      end

      DECODE: begin
        halt_if_o = ev_i.halt_req | (ev_i.ev == EV_DBG);
        halt_id_o = ev_i.halt_req;
        case (ev_i.ev)
          EV_REDIRECT: begin
            pc_set_o = 1'b1;
            pc_mux_o = PC_JUMP;
            if (dbg_req_i) begin
              state_d = DBG_SIGNAL;
            end
          end
          EV_FLUSH_INT, EV_FLUSH_MRET, EV_FLUSH_OTHER: begin
            state_d = FLUSH;
          end
          EV_IRQ: begin
            state_d = IRQ_TAKEN;
          end
          // debug entry is held off until ID can accept it
          EV_DBG: begin
            if (id_ready_i) begin
              state_d = DBG_SIGNAL;
            end
          end
          default: begin
          end
        endcase
      end

      // single flush cycle, acts on the cause latched in DECODE
      FLUSH: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          state_d = dbg_req_i ? DBG_SIGNAL : DECODE;
          case (cause_q)
            FC_INT: begin
              pc_set_o      = 1'b1;
              pc_mux_o      = PC_EXCEPTION;
              exc_ack_o     = 1'b1;
              exc_save_id_o = 1'b1;
            end
            FC_MRET: begin
              pc_set_o         = 1'b1;
              pc_mux_o         = PC_ERET;
              exc_restore_id_o = 1'b1;
            end
            default: begin
              halt_if_o = dbg_req_i;
            end
          endcase
        end else begin
          // mret still restores the pc before going to sleep
          if (cause_q == FC_MRET) begin
            pc_set_o         = 1'b1;
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
          end
          state_d = dbg_req_i ? DBG_SIGNAL_SLEEP : SLEEP;
        end
      end

      IRQ_TAKEN: begin
        pc_set_o      = 1'b1;
        pc_mux_o      = PC_EXCEPTION;
        exc_ack_o     = 1'b1;
        irq_ack_o     = 1'b1;
        // instr in ID already retired or was invalid
        exc_save_if_o = 1'b1;
        state_d       = DECODE;
      end

      //////////////////////////////////////////////////
      // debug handshake
      //////////////////////////////////////////////////

      // pipe is quiet, hand control to the debugger
      DBG_SIGNAL: begin
        dbg_ack_o = 1'b1;
        halt_if_o = 1'b1;
        state_d   = DBG_WAIT;
      end

      DBG_SIGNAL_SLEEP: begin
        dbg_ack_o = 1'b1;
        halt_if_o = 1'b1;
        state_d   = DBG_WAIT_SLEEP;
      end

      // debugger owns the core until stall drops
      DBG_WAIT: begin
        halt_if_o = 1'b1;
        if (dbg_jump_req_i) begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_DBG_NPC;
        end
        if (!dbg_stall_i) begin
          state_d = DECODE;
        end
      end

      DBG_WAIT_SLEEP: begin
        halt_if_o = 1'b1;
        // a debug jump means the core should run afterwards
        if (dbg_jump_req_i) begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_DBG_NPC;
          state_d  = DBG_WAIT;
        end
        if (!dbg_stall_i) begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state and flush cause registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
      cause_q <= FC_OTHER;
    end else begin
      state_q <= state_d;
      // capture on the DECODE to FLUSH step only
      if (state_q == DECODE && state_d == FLUSH) begin
        cause_q <= cause_d;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/core_ctrl.sv
`default_nettype none

module core_ctrl (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               fetch_enable_i,
  output logic               ctrl_busy_o,
  output logic               is_decoding_o,

  // decoder
  output logic               deassert_we_o,
  input  logic               illegal_insn_i,
  input  logic               mret_insn_i,
  input  logic               pipe_flush_i,
  input  logic               ebrk_insn_i,
  input  logic               instr_valid_i,

  // prefetcher
  output logic               instr_req_o,
  output logic               pc_set_o,
  output fetch_pkg::pc_sel_e pc_mux_o,

  // branch and jump
  input  logic               branch_in_id_i,
  input  logic               branch_taken_ex_i,
  input  logic               branch_set_i,
  input  logic               jump_set_i,
  input  logic               instr_multicycle_i,

  // exceptions
  input  logic               int_req_i,
  input  logic               ext_req_i,
  output logic               exc_ack_o,
  output logic               irq_ack_o,
  output logic               exc_save_if_o,
  output logic               exc_save_id_o,
  output logic               exc_restore_id_o,

  // debug
  input  logic               dbg_req_i,
  output logic               dbg_ack_o,
  input  logic               dbg_stall_i,
  input  logic               dbg_jump_req_i,

  // pipeline control
  output logic               halt_if_o,
  output logic               halt_id_o,
  input  logic               id_ready_i
);

  id_event_if ev_if ();

  assign is_decoding_o = ev_if.is_decoding;

  id_event_arbiter id_event_arbiter_i (
    .ev_o               (ev_if.arb),
    .instr_valid_i      (instr_valid_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .int_req_i          (int_req_i),
    .mret_insn_i        (mret_insn_i),
    .pipe_flush_i       (pipe_flush_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .ext_req_i          (ext_req_i),
    .instr_multicycle_i (instr_multicycle_i),
    .branch_in_id_i     (branch_in_id_i),
    .branch_taken_ex_i  (branch_taken_ex_i),
    .dbg_req_i          (dbg_req_i),
    .illegal_insn_i     (illegal_insn_i),
    .deassert_we_o      (deassert_we_o)
  );

  ctrl_fsm ctrl_fsm_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_enable_i   (fetch_enable_i),
    .ext_req_i        (ext_req_i),
    .dbg_req_i        (dbg_req_i),
    .dbg_stall_i      (dbg_stall_i),
    .dbg_jump_req_i   (dbg_jump_req_i),
    .id_ready_i       (id_ready_i),
    .ev_i             (ev_if.fsm),
    .ctrl_busy_o      (ctrl_busy_o),
    .instr_req_o      (instr_req_o),
    .pc_set_o         (pc_set_o),
    .pc_mux_o         (pc_mux_o),
    .halt_if_o        (halt_if_o),
    .halt_id_o        (halt_id_o),
    .exc_ack_o        (exc_ack_o),
    .irq_ack_o        (irq_ack_o),
    .exc_save_if_o    (exc_save_if_o),
    .exc_save_id_o    (exc_save_id_o),
    .exc_restore_id_o (exc_restore_id_o),
    .dbg_ack_o        (dbg_ack_o)
  );

endmodule

`default_nettype wire

// File: verif/core_ctrl_tb.sv
`default_nettype none

module core_ctrl_tb;
  import fetch_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_MARGIN = 20;
  localparam int IN_W           = 17;
  localparam int OUT_W          = 13;
  localparam int unsigned SEED  = 32'h8fdc_b240;

  //////////////////////////////////////////////////
  // stimulus and expected bit positions
  //////////////////////////////////////////////////

  // one bit per DUT input
  localparam logic [IN_W-1:0] IN_NONE = 17'h00000;
  localparam logic [IN_W-1:0] IN_FE   = 17'h00001;
  localparam logic [IN_W-1:0] IN_IV   = 17'h00002;
  localparam logic [IN_W-1:0] IN_BR   = 17'h00004;
  localparam logic [IN_W-1:0] IN_JMP  = 17'h00008;
  localparam logic [IN_W-1:0] IN_INT  = 17'h00010;
  localparam logic [IN_W-1:0] IN_MRET = 17'h00020;
  localparam logic [IN_W-1:0] IN_WFI  = 17'h00040;
  localparam logic [IN_W-1:0] IN_EBRK = 17'h00080;
  localparam logic [IN_W-1:0] IN_EXT  = 17'h00100;
  localparam logic [IN_W-1:0] IN_MC   = 17'h00200;
  localparam logic [IN_W-1:0] IN_BID  = 17'h00400;
  localparam logic [IN_W-1:0] IN_BTX  = 17'h00800;
  localparam logic [IN_W-1:0] IN_DREQ = 17'h01000;
  localparam logic [IN_W-1:0] IN_DSTL = 17'h02000;
  localparam logic [IN_W-1:0] IN_DJMP = 17'h04000;
  localparam logic [IN_W-1:0] IN_IDR  = 17'h08000;
  localparam logic [IN_W-1:0] IN_ILL  = 17'h10000;

  // don't-care sets, randomized per row
  localparam logic [IN_W-1:0] DC_NONE  = 17'h00000;
  // outside DECODE the arbiter is idle and the flush cause is not loaded
  localparam logic [IN_W-1:0] DC_OUT   = IN_IV | IN_BR | IN_JMP | IN_INT | IN_MRET | IN_WFI |
                                         IN_EBRK | IN_MC | IN_BID | IN_BTX | IN_ILL;
  // DECODE with an empty ID stage, only ext_req counts
  localparam logic [IN_W-1:0] DC_IDLE  = DC_OUT & ~IN_IV;
  // valid instr, no irq and no debug pending
  localparam logic [IN_W-1:0] DC_QUIET = IN_MC | IN_BID | IN_BTX;

  // one bit per checked output, pc_mux goes separately
  localparam logic [OUT_W-1:0] O_PS   = 13'h0001;
  localparam logic [OUT_W-1:0] O_HIF  = 13'h0002;
  localparam logic [OUT_W-1:0] O_HID  = 13'h0004;
  localparam logic [OUT_W-1:0] O_EACK = 13'h0008;
  localparam logic [OUT_W-1:0] O_IACK = 13'h0010;
  localparam logic [OUT_W-1:0] O_SIF  = 13'h0020;
  localparam logic [OUT_W-1:0] O_SID  = 13'h0040;
  localparam logic [OUT_W-1:0] O_RID  = 13'h0080;
  localparam logic [OUT_W-1:0] O_DACK = 13'h0100;
  localparam logic [OUT_W-1:0] O_BUSY = 13'h0200;
  localparam logic [OUT_W-1:0] O_DEC  = 13'h0400;
  localparam logic [OUT_W-1:0] O_DWE  = 13'h0800;
  localparam logic [OUT_W-1:0] O_IREQ = 13'h1000;
  // a busy core also requests instructions, both drop in RESET and SLEEP
  localparam logic [OUT_W-1:0] O_RUN  = O_BUSY | O_IREQ;

  string out_names [OUT_W] = '{
    "pc_set_o", "halt_if_o", "halt_id_o", "exc_ack_o", "irq_ack_o", "exc_save_if_o",
    "exc_save_id_o", "exc_restore_id_o", "dbg_ack_o", "ctrl_busy_o", "is_decoding_o",
    "deassert_we_o", "instr_req_o"
  };

  logic clk;
  logic rst_n;
  logic fetch_enable_i, instr_valid_i, branch_set_i, jump_set_i, int_req_i;
  logic mret_insn_i, pipe_flush_i, ebrk_insn_i, ext_req_i, instr_multicycle_i;
  logic branch_in_id_i, branch_taken_ex_i, dbg_req_i, dbg_stall_i, dbg_jump_req_i;
  logic id_ready_i, illegal_insn_i;

  logic    ctrl_busy_o, is_decoding_o, deassert_we_o, instr_req_o, pc_set_o;
  pc_sel_e pc_mux_o;
  logic    exc_ack_o, irq_ack_o, exc_save_if_o, exc_save_id_o, exc_restore_id_o;
  logic    dbg_ack_o, halt_if_o, halt_id_o;

  // outputs packed in the same order as the O_ masks
  logic [OUT_W-1:0] obs;

  logic [IN_W-1:0]  stim_q [$];
  logic [IN_W-1:0]  dc_q [$];
  pc_sel_e          mux_q [$];
  logic [OUT_W-1:0] exp_q [$];

  int errors;
  int checks;
  int cur_row;
  int cycles;

  assign obs = {instr_req_o, deassert_we_o, is_decoding_o, ctrl_busy_o, dbg_ack_o,
                exc_restore_id_o, exc_save_id_o, exc_save_if_o, irq_ack_o, exc_ack_o,
                halt_id_o, halt_if_o, pc_set_o};

  core_ctrl core_ctrl_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .ctrl_busy_o        (ctrl_busy_o),
    .is_decoding_o      (is_decoding_o),
    .deassert_we_o      (deassert_we_o),
    .illegal_insn_i     (illegal_insn_i),
    .mret_insn_i        (mret_insn_i),
    .pipe_flush_i       (pipe_flush_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .instr_valid_i      (instr_valid_i),
    .instr_req_o        (instr_req_o),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .branch_in_id_i     (branch_in_id_i),
    .branch_taken_ex_i  (branch_taken_ex_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .instr_multicycle_i (instr_multicycle_i),
    .int_req_i          (int_req_i),
    .ext_req_i          (ext_req_i),
    .exc_ack_o          (exc_ack_o),
    .irq_ack_o          (irq_ack_o),
    .exc_save_if_o      (exc_save_if_o),
    .exc_save_id_o      (exc_save_id_o),
    .exc_restore_id_o   (exc_restore_id_o),
    .dbg_req_i          (dbg_req_i),
    .dbg_ack_o          (dbg_ack_o),
    .dbg_stall_i        (dbg_stall_i),
    .dbg_jump_req_i     (dbg_jump_req_i),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o),
    .id_ready_i         (id_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic add_row(input logic [IN_W-1:0] stim, input logic [IN_W-1:0] dc,
                         input pc_sel_e mux, input logic [OUT_W-1:0] want);
    stim_q.push_back(stim);
    dc_q.push_back(dc);
    mux_q.push_back(mux);
    exp_q.push_back(want);
  endtask

  task automatic drive_inputs(input logic [IN_W-1:0] v);
    fetch_enable_i     = v[0];
    instr_valid_i      = v[1];
    branch_set_i       = v[2];
    jump_set_i         = v[3];
    int_req_i          = v[4];
    mret_insn_i        = v[5];
    pipe_flush_i       = v[6];
    ebrk_insn_i        = v[7];
    ext_req_i          = v[8];
    instr_multicycle_i = v[9];
    branch_in_id_i     = v[10];
    branch_taken_ex_i  = v[11];
    dbg_req_i          = v[12];
    dbg_stall_i        = v[13];
    dbg_jump_req_i     = v[14];
    id_ready_i         = v[15];
    illegal_insn_i     = v[16];
  endtask

  task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Mismatch %s in row %0d: got 0x%0h, expected 0x%0h", name, cur_row, got, want);
    end
  endtask

  task automatic check_row(input int r);
    cur_row = r;
    for (int b = 0; b < OUT_W; b++) begin
      check_val(out_names[b], {7'b0, obs[b]}, {7'b0, exp_q[r][b]});
    end
    // pc source only means something while pc_set is up
    if (exp_q[r][0]) begin
      check_val("pc_mux_o", {5'b0, pc_mux_o}, {5'b0, mux_q[r]});
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table, one row per cycle
  //////////////////////////////////////////////////

  task automatic build_table;
    // boot, held in RESET until fetch enable
    add_row(IN_NONE, DC_OUT, PC_BOOT, O_DWE);
    add_row(IN_FE, DC_OUT, PC_BOOT, O_DWE);
    add_row(IN_FE, DC_OUT, PC_BOOT, O_PS | O_RUN | O_DWE);
    // first fetch waits on id_ready
    add_row(IN_FE, DC_OUT, PC_BOOT, O_RUN | O_DWE);
    add_row(IN_FE | IN_IDR, DC_OUT, PC_BOOT, O_RUN | O_DWE);
    add_row(IN_FE | IN_IDR, DC_IDLE, PC_BOOT, O_RUN | O_DWE);
    // branch and jump redirect in the same cycle
    add_row(IN_FE | IN_IDR | IN_IV | IN_BR, DC_NONE, PC_JUMP, O_PS | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR | IN_IV | IN_JMP, DC_NONE, PC_JUMP, O_PS | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR | IN_IV | IN_ILL, DC_QUIET, PC_BOOT, O_RUN | O_DEC | O_DWE);
    add_row(IN_FE | IN_IDR | IN_IV, DC_QUIET, PC_BOOT, O_RUN | O_DEC);
    // exception, halts first, then one flush cycle
    add_row(IN_FE | IN_IDR | IN_IV | IN_INT, DC_NONE, PC_BOOT, O_HIF | O_HID | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR, DC_OUT, PC_EXCEPTION,
            O_PS | O_HIF | O_HID | O_EACK | O_SID | O_RUN | O_DWE);
    // mret restores the epc
    add_row(IN_FE | IN_IDR | IN_IV | IN_MRET, DC_NONE, PC_BOOT, O_HIF | O_HID | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR, DC_OUT, PC_ERET, O_PS | O_HIF | O_HID | O_RID | O_RUN | O_DWE);
    // ebreak flush keeps IF running when no debug request waits
    add_row(IN_FE | IN_IDR | IN_IV | IN_EBRK, DC_NONE, PC_BOOT, O_HIF | O_HID | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR, DC_OUT, PC_BOOT, O_HID | O_RUN | O_DWE);
    // wfi with fetch disabled ends in sleep
    add_row(IN_IDR | IN_IV | IN_WFI, DC_NONE, PC_BOOT, O_HIF | O_HID | O_RUN | O_DEC);
    add_row(IN_IDR, DC_OUT, PC_BOOT, O_HIF | O_HID | O_RUN | O_DWE);
    add_row(IN_NONE, DC_OUT, PC_BOOT, O_HIF | O_HID | O_DWE);
    // ext_req wakes the core, irq taken from first fetch
    add_row(IN_EXT, DC_OUT, PC_BOOT, O_HIF | O_HID | O_DWE);
    add_row(IN_EXT, DC_OUT, PC_BOOT, O_HIF | O_HID | O_RUN | O_DWE);
    add_row(IN_NONE, DC_OUT, PC_EXCEPTION, O_PS | O_EACK | O_IACK | O_SIF | O_RUN | O_DWE);
    // irq taken from decode
    add_row(IN_FE | IN_IDR | IN_IV | IN_EXT, DC_NONE, PC_BOOT, O_HIF | O_HID | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR, DC_OUT, PC_EXCEPTION,
            O_PS | O_EACK | O_IACK | O_SIF | O_RUN | O_DWE);
    // multicycle op in ID holds the irq off
    add_row(IN_FE | IN_IDR | IN_IV | IN_EXT | IN_MC, DC_NONE, PC_BOOT, O_RUN | O_DEC);
    // debug entry, held while id_ready is low
    add_row(IN_FE | IN_IV | IN_DREQ, DC_NONE, PC_BOOT, O_HIF | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR | IN_IV | IN_DREQ | IN_DSTL, DC_NONE, PC_BOOT,
            O_HIF | O_RUN | O_DEC);
    add_row(IN_FE | IN_IDR | IN_DSTL, DC_OUT, PC_BOOT, O_DACK | O_HIF | O_RUN | O_DWE);
    add_row(IN_FE | IN_IDR | IN_DSTL, DC_OUT, PC_BOOT, O_HIF | O_RUN | O_DWE);
    add_row(IN_FE | IN_IDR | IN_DSTL | IN_DJMP, DC_OUT, PC_DBG_NPC,
            O_PS | O_HIF | O_RUN | O_DWE);
    // stall drops, back to decode
    add_row(IN_FE | IN_IDR, DC_OUT, PC_BOOT, O_HIF | O_RUN | O_DWE);
    add_row(IN_FE | IN_IDR | IN_IV, DC_QUIET, PC_BOOT, O_RUN | O_DEC);
    // debug from sleep returns to sleep
    add_row(IN_IDR | IN_IV | IN_WFI, DC_NONE, PC_BOOT, O_HIF | O_HID | O_RUN | O_DEC);
    add_row(IN_IDR, DC_OUT, PC_BOOT, O_HIF | O_HID | O_RUN | O_DWE);
    add_row(IN_DREQ, DC_OUT, PC_BOOT, O_HIF | O_HID | O_DWE);
    add_row(IN_DSTL, DC_OUT, PC_BOOT, O_DACK | O_HIF | O_RUN | O_DWE);
    add_row(IN_DSTL, DC_OUT, PC_BOOT, O_HIF | O_RUN | O_DWE);
    add_row(IN_NONE, DC_OUT, PC_BOOT, O_HIF | O_RUN | O_DWE);
    add_row(IN_NONE, DC_OUT, PC_BOOT, O_HIF | O_HID | O_DWE);
    // fetch enable wakes it for good
    add_row(IN_FE, DC_OUT, PC_BOOT, O_HIF | O_HID | O_DWE);
    add_row(IN_FE | IN_IDR, DC_OUT, PC_BOOT, O_RUN | O_DWE);
    add_row(IN_FE | IN_IDR | IN_IV, DC_QUIET, PC_BOOT, O_RUN | O_DEC);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]     rnd;
    logic [IN_W-1:0] stim;
    errors  = 0;
    checks  = 0;
    cur_row = 0;
    rst_n   = 1'b0;
    drive_inputs(IN_NONE);
    void'($urandom(SEED));
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // drive on the falling edge, check a quarter period later
    for (int r = 0; r < stim_q.size(); r++) begin
      rnd  = $urandom();
      stim = (stim_q[r] & ~dc_q[r]) | (rnd[IN_W-1:0] & dc_q[r]);
      drive_inputs(stim);
      #(CLK_PERIOD/4);
      check_row(r);
      @(negedge clk);
    end
    $display("Done after %0d rows: %0d checks, %0d errors", stim_q.size(), checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // limit derived from table length plus reset and some slack
  initial begin
    cycles = 0;
    while (cycles <= stim_q.size() + RESET_CYCLES + TIMEOUT_MARGIN) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the table never finished (%0d errors so far)",
             cycles, errors);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/fetch_pkg.sv
rtl/id_event_if.sv
rtl/id_event_arbiter.sv
rtl/ctrl_fsm.sv
rtl/core_ctrl.sv
verif/core_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module core_ctrl_tb -o core_ctrl_tb || exit 1
out=$(./obj_dir/core_ctrl_tb) || exit 1
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All checks passed" && exit 0 || exit 1
